//--- include/fpAdder_params.svh
// Binary32 field widths and internal datapath widths for the adder
`ifndef FPADDER_PARAMS_SVH
`define FPADDER_PARAMS_SVH

// Operand and result word
`define WORD_WIDTH 32

// Exponent field and its all-ones code for infinity and NaN
`define EXP_WIDTH 8
`define EXP_MAX 255

// Stored fraction bits, hidden bit not included
`define MAN_WIDTH 23

// Hidden bit, fraction, then guard, round and sticky
`define SIG_WIDTH 27

// Aligned significand plus the carry out of the add
`define SUM_WIDTH 28

// Canonical quiet NaN, used for every NaN result
`define QNAN 32'h7FC00000

`endif

//--- source/fpPkg.sv
// Operand class and opcode types for the binary32 adder
`default_nettype none

package fpPkg;

    // Operand class
    // Subnormals and zeros share exponent field 0,
    // infinities and NaNs share the all-ones exponent
    typedef enum logic [2:0]
    {
        ZERO,
        SUBNORMAL,
        NORMAL,
        INF,
        NAN
    } fpClass;

    // Requested operation
    // A subtract is turned into an add by flipping the sign of B
    typedef enum logic
    {
        OP_ADD,
        OP_SUB
    } fpOp;

endpackage

`default_nettype wire

//--- source/fpMask.sv
// Operand unpacking into sign, exponent and fraction, and operand classification
`timescale 1ns/1ps
`default_nettype none

`include "fpAdder_params.svh"

module fpMask
    import fpPkg::*;
(
    input  fpOp                    op,
    input  logic [`WORD_WIDTH-1:0] a,
    input  logic [`WORD_WIDTH-1:0] b,
    output logic                   signA,
    output logic                   signB,
    output logic [`EXP_WIDTH-1:0]  expA,
    output logic [`EXP_WIDTH-1:0]  expB,
    output logic [`MAN_WIDTH-1:0]  manA,
    output logic [`MAN_WIDTH-1:0]  manB,
    output fpClass                 classA,
    output fpClass                 classB
);

    // Class from the exponent and fraction fields
    function automatic fpClass classify
    (
        input logic [`EXP_WIDTH-1:0] expField,
        input logic [`MAN_WIDTH-1:0] manField
    );
        fpClass cls;
        case (expField)
            0:
                cls = (manField == '0) ? ZERO : SUBNORMAL;
            `EXP_MAX:
                cls = (manField == '0) ? INF : NAN;
            default:
                cls = NORMAL;
        endcase
        return cls;
    endfunction

    // Signs, B flipped on a subtract so later stages only add
    assign signA = a[`WORD_WIDTH-1];
    assign signB = b[`WORD_WIDTH-1] ^ (op == OP_SUB);

    // Biased exponents
    assign expA = a[`WORD_WIDTH-2:`MAN_WIDTH];
    assign expB = b[`WORD_WIDTH-2:`MAN_WIDTH];

    // Stored fractions
    assign manA = a[`MAN_WIDTH-1:0];
    assign manB = b[`MAN_WIDTH-1:0];

    always_comb
    begin
        classA = classify(expA, manA);
        classB = classify(expB, manB);
    end

endmodule

`default_nettype wire

//--- source/fpAlign.sv
// Stage 1: special cases, operand ordering by magnitude and sticky alignment shift
`timescale 1ns/1ps
`default_nettype none

`include "fpAdder_params.svh"

module fpAlign
    import fpPkg::*;
(
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   inValid,
    input  logic                   signA,
    input  logic                   signB,
    input  logic [`EXP_WIDTH-1:0]  expA,
    input  logic [`EXP_WIDTH-1:0]  expB,
    input  logic [`MAN_WIDTH-1:0]  manA,
    input  logic [`MAN_WIDTH-1:0]  manB,
    input  fpClass                 classA,
    input  fpClass                 classB,
    output logic                   valid1,
    output logic                   resultSign1,
    output logic                   effSub1,
    output logic                   special1,
    output logic [`EXP_WIDTH-1:0]  bigExp1,
    output logic [`SIG_WIDTH-1:0]  bigSig1,
    output logic [`SIG_WIDTH-1:0]  smallSig1,
    output logic [`WORD_WIDTH-1:0] specialResult1
);

    logic [`EXP_WIDTH-1:0]  effExpA;
    logic [`EXP_WIDTH-1:0]  effExpB;
    logic [`SIG_WIDTH-1:0]  sigA;
    logic [`SIG_WIDTH-1:0]  sigB;
    logic                   aBigger;
    logic [`EXP_WIDTH-1:0]  bigExp;
    logic [`EXP_WIDTH-1:0]  expDiff;
    logic [`SIG_WIDTH-1:0]  bigSig;
    logic [`SIG_WIDTH-1:0]  smallSig;
    logic [`SIG_WIDTH-1:0]  shiftedSig;
    logic                   sticky;
    logic                   isSpecial;
    logic [`WORD_WIDTH-1:0] specialWord;

    // Hidden bit only for normals; subnormals and zeros sit at exponent 1
    assign sigA    = {(classA == NORMAL), manA, 3'b000};
    assign sigB    = {(classB == NORMAL), manB, 3'b000};
    assign effExpA = (classA == NORMAL) ? expA : `EXP_WIDTH'(1);
    assign effExpB = (classB == NORMAL) ? expB : `EXP_WIDTH'(1);

    // Larger magnitude wins, A on a tie
    assign aBigger  = {effExpA, sigA} >= {effExpB, sigB};
    assign bigExp   = aBigger ? effExpA : effExpB;
    assign bigSig   = aBigger ? sigA : sigB;
    assign smallSig = aBigger ? sigB : sigA;
    assign expDiff  = aBigger ? (effExpA - effExpB) : (effExpB - effExpA);

    // Alignment, every bit shifted out is folded into the sticky bit
    assign shiftedSig = smallSig >> expDiff;
    assign sticky     = |(smallSig & ~({`SIG_WIDTH{1'b1}} << expDiff));

    // Results that need no arithmetic
    always_comb
    begin
        isSpecial   = 1'b1;
        specialWord = `QNAN;
        if (classA == NAN || classB == NAN)
            specialWord = `QNAN;
        else if (classA == INF && classB == INF && signA != signB)
            specialWord = `QNAN;
        else if (classA == INF)
            specialWord = {signA, {`EXP_WIDTH{1'b1}}, {`MAN_WIDTH{1'b0}}};
        else if (classB == INF)
            specialWord = {signB, {`EXP_WIDTH{1'b1}}, {`MAN_WIDTH{1'b0}}};
        else if (classA == ZERO && classB == ZERO)
            // Negative zero only when both are negative
            specialWord = {signA & signB, {(`WORD_WIDTH-1){1'b0}}};
        else
            isSpecial = 1'b0;
    end

    always_ff @(posedge clock)
    begin
        if (rst)
            valid1 <= 1'b0;
        else
            valid1 <= inValid;
    end

    always_ff @(posedge clock)
    begin
        resultSign1    <= aBigger ? signA : signB;
        effSub1        <= signA ^ signB;
        special1       <= isSpecial;
        specialResult1 <= specialWord;
        bigExp1        <= bigExp;
        bigSig1        <= bigSig;
        smallSig1      <= {shiftedSig[`SIG_WIDTH-1:1], shiftedSig[0] | sticky};
    end

endmodule

`default_nettype wire

//--- source/fpAddSub.sv
// Stage 2: magnitude addition or subtraction of the aligned significands
`timescale 1ns/1ps
`default_nettype none

`include "fpAdder_params.svh"

module fpAddSub
(
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   valid1,
    input  logic                   resultSign1,
    input  logic                   effSub1,
    input  logic                   special1,
    input  logic [`EXP_WIDTH-1:0]  bigExp1,
    input  logic [`SIG_WIDTH-1:0]  bigSig1,
    input  logic [`SIG_WIDTH-1:0]  smallSig1,
    input  logic [`WORD_WIDTH-1:0] specialResult1,
    output logic                   valid2,
    output logic                   sign2,
    output logic                   special2,
    output logic [`EXP_WIDTH-1:0]  exp2,
    output logic [`SUM_WIDTH-1:0]  sum2,
    output logic [`WORD_WIDTH-1:0] specialResult2
);

    logic [`SUM_WIDTH-1:0] sumNext;

    // Big operand is never smaller, so the difference stays non-negative
    always_comb
    begin
        if (effSub1)
            sumNext = {1'b0, bigSig1} - {1'b0, smallSig1};
        else
            sumNext = {1'b0, bigSig1} + {1'b0, smallSig1};
    end

    always_ff @(posedge clock)
    begin
        if (rst)
            valid2 <= 1'b0;
        else
            valid2 <= valid1;
    end

    // Sign, exponent and special result ride along with the sum
    always_ff @(posedge clock)
    begin
        sign2          <= resultSign1;
        exp2           <= bigExp1;
        sum2           <= sumNext;
        special2       <= special1;
        specialResult2 <= specialResult1;
    end

endmodule

`default_nettype wire

//--- source/fpRoundPack.sv
// Stage 3: normalization, round to nearest even, overflow and packing of the result
`timescale 1ns/1ps
`default_nettype none

`include "fpAdder_params.svh"

module fpRoundPack
(
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   valid2,
    input  logic                   sign2,
    input  logic                   special2,
    input  logic [`EXP_WIDTH-1:0]  exp2,
    input  logic [`SUM_WIDTH-1:0]  sum2,
    input  logic [`WORD_WIDTH-1:0] specialResult2,
    output logic                   outValid,
    output logic [`WORD_WIDTH-1:0] result
);

    logic [4:0]             leadZeros;
    logic [`EXP_WIDTH-1:0]  maxShift;
    logic [`EXP_WIDTH-1:0]  shiftAmt;
    logic [`SIG_WIDTH-1:0]  normSig;
    logic [9:0]             normExp;
    logic                   roundUp;
    logic [`MAN_WIDTH+1:0]  roundedSig;
    logic [9:0]             finalExp;
    logic [`WORD_WIDTH-1:0] packWord;

    // Leading zeros below the carry bit, highest set bit wins
    always_comb
    begin
        leadZeros = 5'(`SIG_WIDTH);
        for (int i = 0; i < `SIG_WIDTH; i++)
        begin
            if (sum2[i])
                leadZeros = 5'(`SIG_WIDTH - 1 - i);
        end
    end

    // Left shift may not take the exponent below 1, which gives subnormals
    assign maxShift = exp2 - `EXP_WIDTH'(1);
    assign shiftAmt = ({3'b000, leadZeros} < maxShift) ? {3'b000, leadZeros} : maxShift;

    always_comb
    begin
        if (sum2[`SUM_WIDTH-1])
        begin
            // Carry out, one place right with the dropped bit kept in sticky
            normSig = {sum2[`SUM_WIDTH-1:2], sum2[1] | sum2[0]};
            normExp = {2'b00, exp2} + 10'd1;
        end
        else
        begin
            normSig = sum2[`SIG_WIDTH-1:0] << shiftAmt;
            normExp = {2'b00, exp2} - {2'b00, shiftAmt};
        end
    end

    // Guard at bit 2, round at bit 1, sticky at bit 0
    assign roundUp    = normSig[2] & (normSig[3] | normSig[1] | normSig[0]);
    assign roundedSig = {1'b0, normSig[`SIG_WIDTH-1:3]} + {{(`MAN_WIDTH+1){1'b0}}, roundUp};

    // Rounding carry bumps the exponent; no hidden bit means a subnormal
    always_comb
    begin
        if (roundedSig[`MAN_WIDTH+1])
            finalExp = normExp + 10'd1;
        else if (roundedSig[`MAN_WIDTH])
            finalExp = normExp;
        else
            finalExp = '0;
    end

    always_comb
    begin
        if (special2)
            packWord = specialResult2;
        else if (sum2 == '0)
            // Exact cancellation is always +0
            packWord = '0;
        else if (finalExp >= 10'(`EXP_MAX))
            packWord = {sign2, {`EXP_WIDTH{1'b1}}, {`MAN_WIDTH{1'b0}}};
        else
            // Fraction is all zeros after a rounding carry
            packWord = {sign2, finalExp[`EXP_WIDTH-1:0], roundedSig[`MAN_WIDTH-1:0]};
    end

    always_ff @(posedge clock)
    begin
        if (rst)
            outValid <= 1'b0;
        else
            outValid <= valid2;
    end

    always_ff @(posedge clock)
    begin
        result <= packWord;
    end

endmodule

`default_nettype wire

//--- source/fpAdder.sv
// Top level of the three-stage binary32 adder and subtractor
`timescale 1ns/1ps
`default_nettype none

`include "fpAdder_params.svh"

module fpAdder
    import fpPkg::*;
(
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   inValid,
    input  fpOp                    op,
    input  logic [`WORD_WIDTH-1:0] a,
    input  logic [`WORD_WIDTH-1:0] b,
    output logic                   outValid,
    output logic [`WORD_WIDTH-1:0] result
);

    // Unpacked operands
    logic                   signA;
    logic                   signB;
    logic [`EXP_WIDTH-1:0]  expA;
    logic [`EXP_WIDTH-1:0]  expB;
    logic [`MAN_WIDTH-1:0]  manA;
    logic [`MAN_WIDTH-1:0]  manB;
    fpClass                 classA;
    fpClass                 classB;

    // Stage 1 to stage 2
    logic                   valid1;
    logic                   resultSign1;
    logic                   effSub1;
    logic                   special1;
    logic [`EXP_WIDTH-1:0]  bigExp1;
    logic [`SIG_WIDTH-1:0]  bigSig1;
    logic [`SIG_WIDTH-1:0]  smallSig1;
    logic [`WORD_WIDTH-1:0] specialResult1;

    // Stage 2 to stage 3
    logic                   valid2;
    logic                   sign2;
    logic                   special2;
    logic [`EXP_WIDTH-1:0]  exp2;
    logic [`SUM_WIDTH-1:0]  sum2;
    logic [`WORD_WIDTH-1:0] specialResult2;

    fpMask mask
    (
        .op(op), .a(a), .b(b),
        .signA(signA), .signB(signB), .expA(expA), .expB(expB),
        .manA(manA), .manB(manB), .classA(classA), .classB(classB)
    );

    fpAlign align
    (
        .clock(clock), .rst(rst), .inValid(inValid),
        .signA(signA), .signB(signB), .expA(expA), .expB(expB),
        .manA(manA), .manB(manB), .classA(classA), .classB(classB),
        .valid1(valid1), .resultSign1(resultSign1), .effSub1(effSub1),
        .special1(special1), .bigExp1(bigExp1), .bigSig1(bigSig1),
        .smallSig1(smallSig1), .specialResult1(specialResult1)
    );

    fpAddSub addSub
    (
        .clock(clock), .rst(rst),
        .valid1(valid1), .resultSign1(resultSign1), .effSub1(effSub1),
        .special1(special1), .bigExp1(bigExp1), .bigSig1(bigSig1),
        .smallSig1(smallSig1), .specialResult1(specialResult1),
        .valid2(valid2), .sign2(sign2), .special2(special2), .exp2(exp2),
        .sum2(sum2), .specialResult2(specialResult2)
    );

    fpRoundPack roundPack
    (
        .clock(clock), .rst(rst),
        .valid2(valid2), .sign2(sign2), .special2(special2), .exp2(exp2),
        .sum2(sum2), .specialResult2(specialResult2),
        .outValid(outValid), .result(result)
    );

endmodule

`default_nettype wire

//--- bench/fpAdderTb.sv
// Testbench for the binary32 adder with reference model, scoreboard and test reporting
`timescale 1ns/1ps
`default_nettype none

`include "fpAdder_params.svh"

module fpAdderTb
    import fpPkg::*;
();

    logic        clock;
    logic        rst;
    logic        inValid;
    fpOp         op;
    logic [31:0] a;
    logic [31:0] b;
    logic        outValid;
    logic [31:0] result;

    // Expected results and the cycle each request was issued in
    logic [31:0] expQ[$];
    int          issueQ[$];
    int          seed;
    int          cycleCount;
    int          passCount;
    int          errorCount;
    int          checkCount;
    int          errMark;
    int          chkMark;

    fpAdder UUT
    (
        .clock(clock), .rst(rst), .inValid(inValid), .op(op), .a(a), .b(b),
        .outValid(outValid), .result(result)
    );

    initial
    begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock)
        cycleCount <= cycleCount + 1;

    // Exact magnitude in units of the smallest subnormal
    function automatic logic [299:0] decodeMag(input logic [31:0] w);
        logic [299:0] sig;
        sig = '0;
        sig[22:0] = w[22:0];
        if (w[30:23] == 8'd0)
            return sig;
        sig[23] = 1'b1;
        return sig << (w[30:23] - 8'd1);
    endfunction

    // Exact signed sum, then round to nearest even into binary32
    function automatic logic [31:0] refAdd(input logic [31:0] x, input logic [31:0] y,
                                           input bit sub);
        logic         sx;
        logic         sy;
        logic         sr;
        logic         nanX;
        logic         nanY;
        logic         infX;
        logic         infY;
        logic         roundUp;
        logic [299:0] one;
        logic [299:0] mx;
        logic [299:0] my;
        logic [299:0] mag;
        logic [299:0] keep;
        logic [299:0] rem;
        logic [299:0] half;
        int           msb;
        int           sh;
        one  = 300'd1;
        sx   = x[31];
        sy   = y[31] ^ sub;
        nanX = (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
        nanY = (y[30:23] == 8'hFF) && (y[22:0] != 23'd0);
        infX = (x[30:23] == 8'hFF) && (x[22:0] == 23'd0);
        infY = (y[30:23] == 8'hFF) && (y[22:0] == 23'd0);
        if (nanX || nanY)
            return `QNAN;
        if (infX && infY && sx != sy)
            return `QNAN;
        if (infX)
            return {sx, 8'hFF, 23'd0};
        if (infY)
            return {sy, 8'hFF, 23'd0};
        mx = decodeMag(x);
        my = decodeMag(y);
        if (mx == '0 && my == '0)
            return {sx & sy, 31'd0};
        if (sx == sy)
        begin
            mag = mx + my;
            sr  = sx;
        end
        else if (mx >= my)
        begin
            mag = mx - my;
            sr  = sx;
        end
        else
        begin
            mag = my - mx;
            sr  = sy;
        end
        if (mag == '0)
            return 32'd0;
        // Below 2^24 units the value is exact and the bits are the encoding
        if (mag < (one << 24))
            return {sr, mag[30:0]};
        msb = 0;
        for (int i = 0; i < 300; i++)
        begin
            if (mag[i])
                msb = i;
        end
        sh      = msb - 23;
        keep    = mag >> sh;
        rem     = mag & ((one << sh) - one);
        half    = one << (sh - 1);
        roundUp = (rem > half) || (rem == half && keep[0]);
        keep    = keep + {299'd0, roundUp};
        if (keep[24])
        begin
            keep = keep >> 1;
            sh   = sh + 1;
        end
        if (sh + 1 >= 255)
            return {sr, 8'hFF, 23'd0};
        return {sr, 8'(sh + 1), keep[22:0]};
    endfunction

    function automatic logic [31:0] randBits();
        return $random(seed);
    endfunction

    // Random sign and fraction, biased exponent in lo..hi
    function automatic logic [31:0] randFloat(input int lo, input int hi);
        logic [31:0] r;
        logic [31:0] pick;
        logic [31:0] e;
        r    = $random(seed);
        pick = $random(seed);
        e    = 32'(lo) + ({1'b0, pick[30:0]} % 32'(hi - lo + 1));
        return {r[31], e[7:0], r[22:0]};
    endfunction

    task automatic issue(input logic [31:0] x, input logic [31:0] y, input bit sub);
        inValid = 1'b1;
        a       = x;
        b       = y;
        op      = sub ? OP_SUB : OP_ADD;
        expQ.push_back(refAdd(x, y, sub));
        issueQ.push_back(cycleCount);
        @(posedge clock);
        #1;
        inValid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clock);
            #1;
        end
    endtask

    // Wait for outstanding results, then report the test
    task automatic finishTest(input string name);
        int waited;
        waited = 0;
        while (expQ.size() != 0 && waited < 10)
        begin
            @(posedge clock);
            #1;
            waited++;
        end
        if (expQ.size() != 0)
        begin
            $display("ERROR: %0d request(s) in test %s left unanswered after %0d cycles",
                     expQ.size(), name, waited);
            errorCount += expQ.size();
            expQ.delete();
            issueQ.delete();
        end
        idle(4);
        $display("Test %s done: %0d results checked, %0d errors", name,
                 checkCount - chkMark, errorCount - errMark);
        errMark = errorCount;
        chkMark = checkCount;
    endtask

    // Scoreboard sampled mid-cycle on the falling edge
    always @(negedge clock)
    begin
        if (!rst && outValid === 1'b1)
        begin
            if (expQ.size() == 0)
            begin
                $display("ERROR at time %0t: outValid high with no pending request", $time);
                errorCount++;
            end
            else
            begin
                checkCount++;
                if (result !== expQ[0])
                begin
                    $display("CHECK FAILED at time %0t: result expected %h, actual %h",
                             $time, expQ[0], result);
                    errorCount++;
                end
                else if (cycleCount != issueQ[0] + 3)
                begin
                    $display("CHECK FAILED at time %0t: outValid latency expected 3, actual %0d",
                             $time, cycleCount - issueQ[0]);
                    errorCount++;
                end
                else
                    passCount++;
                void'(expQ.pop_front());
                void'(issueQ.pop_front());
            end
        end
    end

    initial
    begin
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] r;
        seed       = 52;
        rst        = 1'b1;
        inValid    = 1'b0;
        op         = OP_ADD;
        a          = 32'd0;
        b          = 32'd0;
        cycleCount = 0;
        passCount  = 0;
        errorCount = 0;
        checkCount = 0;
        errMark    = 0;
        chkMark    = 0;
        repeat (2) @(posedge clock);
        #1;
        rst = 1'b0;
        if (outValid !== 1'b0)
        begin
            $display("CHECK FAILED at time %0t: outValid expected 0, actual %b", $time, outValid);
            errorCount++;
        end

        // Back to back normals with half of them sharing an exponent
        repeat (400)
        begin
            x = randFloat(1, 254);
            y = randFloat(1, 254);
            r = randBits();
            if (r[1])
                y[30:23] = x[30:23];
            issue(x, y, r[0]);
        end
        finishTest("random normal");

        issue(32'h7FC00000, 32'h3F800000, 1'b0);
        issue(32'h3F800000, 32'hFF800001, 1'b1);
        issue(32'h7F800000, 32'h7F800000, 1'b1);
        issue(32'hFF800000, 32'h7F800000, 1'b0);
        issue(32'h7F800000, 32'h7F800000, 1'b0);
        issue(32'hFF800000, 32'h40A00000, 1'b0);
        issue(32'h3F800000, 32'h7F800000, 1'b1);
        issue(32'h00000000, 32'h00000000, 1'b0);
        issue(32'h80000000, 32'h80000000, 1'b0);
        issue(32'h80000000, 32'h00000000, 1'b1);
        issue(32'h00000000, 32'h80000000, 1'b0);
        issue(32'h80000000, 32'h3F800000, 1'b0);
        repeat (30)
        begin
            x = randFloat(0, 254);
            r = randBits();
            // Exact cancellation either way round
            if (r[0])
                issue(x, x, 1'b1);
            else
                issue(x, x ^ 32'h80000000, 1'b0);
        end
        finishTest("special operands");

        repeat (300)
        begin
            r = randBits();
            x = randFloat(0, 2);
            y = r[1] ? randFloat(0, 2) : randFloat(1, 30);
            if (r[2])
            begin
                // Difference of close normals drops below the normal range
                x = randFloat(1, 3);
                y = x ^ {20'd0, r[15:4]};
                issue(x, y, 1'b1);
            end
            else
                issue(x, y, r[0]);
        end
        finishTest("subnormals");

        issue(32'h3F800000, 32'h33800000, 1'b0);
        issue(32'h3F800001, 32'h33800000, 1'b0);
        issue(32'h3FFFFFFF, 32'h33800000, 1'b0);
        issue(32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0);
        issue(32'hFF7FFFFF, 32'h7F7FFFFF, 1'b1);
        issue(32'h7F7FFFFF, 32'h73000000, 1'b0);
        repeat (300)
        begin
            r = randBits();
            if (r[3])
            begin
                // B is half an ulp of A, or just around it
                x = randFloat(30, 250);
                y = {r[31], x[30:23] - 8'd24, r[1] ? 23'd0 : r[24:2]};
            end
            else
            begin
                x = randFloat(252, 254);
                y = randFloat(250, 254);
                y[31] = x[31] ^ r[4];
            end
            issue(x, y, r[0]);
        end
        finishTest("rounding and overflow");

        repeat (200)
        begin
            r = randBits();
            issue(randFloat(0, 254), randFloat(0, 254), r[0]);
            idle(int'(r[2:1]));
        end
        finishTest("pipeline gaps");

        $display("Results: %0d passed, %0d errors", passCount, errorCount);
        if (errorCount == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- fpAdder.f
+incdir+include
source/fpPkg.sv
source/fpMask.sv
source/fpAlign.sv
source/fpAddSub.sv
source/fpRoundPack.sv
source/fpAdder.sv
bench/fpAdderTb.sv

//--- run.sh
#!/bin/bash
# Build and run the adder testbench with Verilator, then scan the log
set -o pipefail
verilator --binary --timing -Wno-fatal --top-module fpAdderTb -f fpAdder.f -o fpAdderSim \
    && ./obj_dir/fpAdderSim 2>&1 | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }
if grep -q "Simulation FAILED" sim.log
then
    exit 1
fi
exit 0
